// ==== src/replay_pkg.sv ====
// Record and replay shared definitions
package replay_pkg;

   // Stream widths, scaled down from the capture path
   localparam int DATA_W = 64;
   localparam int KEEP_W = 8;
   localparam int USER_W = 16;

   // Beat memory geometry
   localparam int MEM_DEPTH = 32;
   localparam int ADDR_W = 5;

   // Output FIFO sizing
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_PTR_W = 3;
   // One issued read plus one read still in the memory pipeline
   localparam int FIFO_MARGIN = 2;

   // Memory word layout matches the stream payload, tdata in the low bits
   typedef struct packed {
      logic              tlast;
      logic [USER_W-1:0] tuser;
      logic [KEEP_W-1:0] tkeep;
      logic [DATA_W-1:0] tdata;
   } beat_t;

   typedef logic [ADDR_W-1:0] beat_addr_t;
   typedef logic [ADDR_W:0] beat_count_t;
   typedef logic [15:0] replay_count_t;
   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
   typedef logic [FIFO_PTR_W:0] fifo_count_t;

   typedef logic [1:0] reg_addr_t;
   typedef logic [31:0] reg_data_t;

   localparam reg_addr_t REG_CTRL = 2'd0;
   localparam reg_addr_t REG_REPLAY_COUNT = 2'd1;
   localparam reg_addr_t REG_STORED = 2'd2;
   localparam reg_addr_t REG_STATUS = 2'd3;

   // Control register bit positions
   localparam int CTRL_SW_RST_BIT = 0;
   localparam int CTRL_START_BIT = 1;
   localparam int CTRL_WR_DONE_BIT = 2;

   typedef enum logic [1:0] {
      READ_IDLE,
      READ_RUN,
      READ_DRAIN
   } reader_state_t;

endpackage

// ==== src/replay_regs.sv ====
// Replay control and status registers
`timescale 1ns/1ps

module replay_regs (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      reg_wr_i,
   input  logic                      reg_rd_i,
   input  replay_pkg::reg_addr_t     reg_addr_i,
   input  replay_pkg::reg_data_t     reg_wdata_i,
   output replay_pkg::reg_data_t     reg_rdata_o,
   input  replay_pkg::beat_count_t   stored_count_i,
   input  logic                      busy_i,
   input  replay_pkg::replay_count_t replays_done_i,
   output logic                      sw_rst_o,
   output logic                      start_o,
   output logic                      wr_done_o,
   output replay_pkg::replay_count_t replay_count_o
);

   replay_pkg::reg_data_t rd_sel;

   // Read mux, sampled into reg_rdata_o on a read strobe
   always_comb begin
      rd_sel = '0;
      case (reg_addr_i)
         replay_pkg::REG_CTRL: rd_sel[replay_pkg::CTRL_WR_DONE_BIT] = wr_done_o;
         replay_pkg::REG_REPLAY_COUNT: rd_sel[15:0] = replay_count_o;
         replay_pkg::REG_STORED: rd_sel[replay_pkg::ADDR_W:0] = stored_count_i;
         replay_pkg::REG_STATUS: begin
            rd_sel[16] = busy_i;
            rd_sel[15:0] = replays_done_i;
         end
         default: rd_sel = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sw_rst_o <= 1'b0;
         start_o <= 1'b0;
         wr_done_o <= 1'b0;
         replay_count_o <= '0;
         reg_rdata_o <= '0;
      end else begin
         // Pulses last a single cycle
         sw_rst_o <= 1'b0;
         start_o <= 1'b0;
         if (reg_wr_i) begin
            case (reg_addr_i)
               replay_pkg::REG_CTRL: begin
                  sw_rst_o <= reg_wdata_i[replay_pkg::CTRL_SW_RST_BIT];
                  start_o <= reg_wdata_i[replay_pkg::CTRL_START_BIT];
                  wr_done_o <= reg_wdata_i[replay_pkg::CTRL_WR_DONE_BIT];
               end
               replay_pkg::REG_REPLAY_COUNT: replay_count_o <= reg_wdata_i[15:0];
               default: ;
            endcase
         end
         // Holds until the next read
         if (reg_rd_i) begin
            reg_rdata_o <= rd_sel;
         end
      end
   end

endmodule

// ==== src/capture_writer.sv ====
// Input beat capture
`timescale 1ns/1ps

module capture_writer (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    sw_rst_i,
   input  logic                    wr_done_i,
   input  logic                    busy_i,
   input  replay_pkg::beat_t       s_beat_i,
   input  logic                    s_valid_i,
   output logic                    s_ready_o,
   output logic                    wr_en_o,
   output replay_pkg::beat_addr_t  wr_addr_o,
   output replay_pkg::beat_t       wr_beat_o,
   output replay_pkg::beat_count_t stored_count_o
);

   logic store_full;
   logic accept;

   assign store_full = (stored_count_o == replay_pkg::beat_count_t'(replay_pkg::MEM_DEPTH));

   // Capture is closed once wr_done is set, the store fills or a replay runs
   assign s_ready_o = !wr_done_i && !busy_i && !store_full;
   assign accept = s_valid_i && s_ready_o;

   // The stored count doubles as the next free slot
   assign wr_en_o = accept;
   assign wr_addr_o = stored_count_o[replay_pkg::ADDR_W-1:0];
   assign wr_beat_o = s_beat_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stored_count_o <= '0;
      end else if (sw_rst_i) begin
         stored_count_o <= '0;
      end else if (accept) begin
         stored_count_o <= stored_count_o + 1'b1;
      end
   end

endmodule

// ==== src/beat_store.sv ====
// On-chip beat memory
`timescale 1ns/1ps

module beat_store (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   sw_rst_i,
   input  logic                   wr_en_i,
   input  replay_pkg::beat_addr_t wr_addr_i,
   input  replay_pkg::beat_t      wr_beat_i,
   input  logic                   rd_en_i,
   input  replay_pkg::beat_addr_t rd_addr_i,
   output replay_pkg::beat_t      rd_beat_o,
   output logic                   rd_valid_o
);

   replay_pkg::beat_t mem [0:replay_pkg::MEM_DEPTH-1];

   // One write port, one registered read port
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_beat_i;
      end
      if (rd_en_i) begin
         rd_beat_o <= mem[rd_addr_i];
      end
   end

   // Valid follows the read enable by one cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_valid_o <= 1'b0;
      end else if (sw_rst_i) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

endmodule

// ==== src/replay_reader.sv ====
// Replay read sequencer
`timescale 1ns/1ps

module replay_reader (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      sw_rst_i,
   input  logic                      start_i,
   input  logic                      wr_done_i,
   input  replay_pkg::replay_count_t replay_count_i,
   input  replay_pkg::beat_count_t   stored_count_i,
   input  logic                      nearly_full_i,
   output logic                      rd_en_o,
   output replay_pkg::beat_addr_t    rd_addr_o,
   output logic                      busy_o,
   output replay_pkg::replay_count_t replays_done_o
);

   replay_pkg::reader_state_t state;
   replay_pkg::beat_count_t   last_idx;
   replay_pkg::replay_count_t passes_next;
   logic                      start_ok;
   logic                      pass_end;

   // Start needs a closed capture, something stored and a nonzero count
   assign start_ok = start_i && wr_done_i && (stored_count_i != '0) && (replay_count_i != '0);

   assign last_idx = stored_count_i - 1'b1;
   assign pass_end = (rd_addr_o == last_idx[replay_pkg::ADDR_W-1:0]);
   assign passes_next = replays_done_o + 1'b1;

   // Reads pause while the FIFO has no room for the pipeline
   assign rd_en_o = (state == replay_pkg::READ_RUN) && !nearly_full_i;
   assign busy_o = (state != replay_pkg::READ_IDLE);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state <= replay_pkg::READ_IDLE;
         rd_addr_o <= '0;
         replays_done_o <= '0;
      end else if (sw_rst_i) begin
         state <= replay_pkg::READ_IDLE;
         rd_addr_o <= '0;
         replays_done_o <= '0;
      end else begin
         case (state)
            replay_pkg::READ_IDLE: begin
               if (start_ok) begin
                  state <= replay_pkg::READ_RUN;
                  rd_addr_o <= '0;
                  replays_done_o <= '0;
               end
            end
            replay_pkg::READ_RUN: begin
               if (rd_en_o) begin
                  if (pass_end) begin
                     // Wrap to the first beat for the next pass
                     rd_addr_o <= '0;
                     replays_done_o <= passes_next;
                     if (passes_next >= replay_count_i) begin
                        state <= replay_pkg::READ_DRAIN;
                     end
                  end else begin
                     rd_addr_o <= rd_addr_o + 1'b1;
                  end
               end
            end
            // Last read is still in the memory pipeline
            replay_pkg::READ_DRAIN: state <= replay_pkg::READ_IDLE;
            default: state <= replay_pkg::READ_IDLE;
         endcase
      end
   end

endmodule

// ==== src/beat_fifo.sv ====
// Fall-through output FIFO
`timescale 1ns/1ps

module beat_fifo (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              sw_rst_i,
   input  logic              wr_en_i,
   input  replay_pkg::beat_t wr_beat_i,
   output logic              nearly_full_o,
   output replay_pkg::beat_t m_beat_o,
   output logic              m_valid_o,
   input  logic              m_ready_i
);

   replay_pkg::beat_t       mem [0:replay_pkg::FIFO_DEPTH-1];
   replay_pkg::fifo_ptr_t   wr_ptr;
   replay_pkg::fifo_ptr_t   rd_ptr;
   replay_pkg::fifo_count_t count;
   logic                    full;
   logic                    push;
   logic                    pop;

   assign full = (count == replay_pkg::fifo_count_t'(replay_pkg::FIFO_DEPTH));
   assign nearly_full_o = (count >=
      replay_pkg::fifo_count_t'(replay_pkg::FIFO_DEPTH - replay_pkg::FIFO_MARGIN));

   // Head entry is shown directly on the output stream
   assign m_valid_o = (count != '0);
   assign m_beat_o = mem[rd_ptr];

   assign push = wr_en_i && !full;
   assign pop = m_valid_o && m_ready_i;

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= wr_beat_i;
      end
   end

   // Pointers wrap naturally since the depth is a power of two
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else if (sw_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== src/replay_top.sv ====
// Packet record and replay engine
`timescale 1ns/1ps

module replay_top (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  replay_pkg::beat_t     s_beat_i,
   input  logic                  s_valid_i,
   output logic                  s_ready_o,
   output replay_pkg::beat_t     m_beat_o,
   output logic                  m_valid_o,
   input  logic                  m_ready_i,
   input  logic                  reg_wr_i,
   input  logic                  reg_rd_i,
   input  replay_pkg::reg_addr_t reg_addr_i,
   input  replay_pkg::reg_data_t reg_wdata_i,
   output replay_pkg::reg_data_t reg_rdata_o
);

   logic                      sw_rst;
   logic                      start;
   logic                      wr_done;
   replay_pkg::replay_count_t replay_count;
   replay_pkg::replay_count_t replays_done;
   logic                      busy;
   replay_pkg::beat_count_t   stored_count;

   logic                      wr_en;
   replay_pkg::beat_addr_t    wr_addr;
   replay_pkg::beat_t         wr_beat;
   logic                      rd_en;
   replay_pkg::beat_addr_t    rd_addr;
   replay_pkg::beat_t         rd_beat;
   logic                      rd_valid;
   logic                      nearly_full;

   replay_regs u_regs (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .reg_wr_i       (reg_wr_i),
      .reg_rd_i       (reg_rd_i),
      .reg_addr_i     (reg_addr_i),
      .reg_wdata_i    (reg_wdata_i),
      .reg_rdata_o    (reg_rdata_o),
      .stored_count_i (stored_count),
      .busy_i         (busy),
      .replays_done_i (replays_done),
      .sw_rst_o       (sw_rst),
      .start_o        (start),
      .wr_done_o      (wr_done),
      .replay_count_o (replay_count)
   );

   capture_writer u_writer (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .sw_rst_i       (sw_rst),
      .wr_done_i      (wr_done),
      .busy_i         (busy),
      .s_beat_i       (s_beat_i),
      .s_valid_i      (s_valid_i),
      .s_ready_o      (s_ready_o),
      .wr_en_o        (wr_en),
      .wr_addr_o      (wr_addr),
      .wr_beat_o      (wr_beat),
      .stored_count_o (stored_count)
   );

   // Stands in for the external DDR memory
   beat_store u_store (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .sw_rst_i   (sw_rst),
      .wr_en_i    (wr_en),
      .wr_addr_i  (wr_addr),
      .wr_beat_i  (wr_beat),
      .rd_en_i    (rd_en),
      .rd_addr_i  (rd_addr),
      .rd_beat_o  (rd_beat),
      .rd_valid_o (rd_valid)
   );

   replay_reader u_reader (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .sw_rst_i       (sw_rst),
      .start_i        (start),
      .wr_done_i      (wr_done),
      .replay_count_i (replay_count),
      .stored_count_i (stored_count),
      .nearly_full_i  (nearly_full),
      .rd_en_o        (rd_en),
      .rd_addr_o      (rd_addr),
      .busy_o         (busy),
      .replays_done_o (replays_done)
   );

   beat_fifo u_fifo (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .sw_rst_i      (sw_rst),
      .wr_en_i       (rd_valid),
      .wr_beat_i     (rd_beat),
      .nearly_full_o (nearly_full),
      .m_beat_o      (m_beat_o),
      .m_valid_o     (m_valid_o),
      .m_ready_i     (m_ready_i)
   );

endmodule

// ==== tests/replay_tb.sv ====
// Record and replay testbench
`timescale 1ns/1ps

module replay_tb;

   logic                  clk_i;
   logic                  rst_n_i;
   replay_pkg::beat_t     s_beat_i;
   logic                  s_valid_i;
   logic                  s_ready_o;
   replay_pkg::beat_t     m_beat_o;
   logic                  m_valid_o;
   logic                  m_ready_i;
   logic                  reg_wr_i;
   logic                  reg_rd_i;
   replay_pkg::reg_addr_t reg_addr_i;
   replay_pkg::reg_data_t reg_wdata_i;
   replay_pkg::reg_data_t reg_rdata_o;

   // Beats accepted by the store, and beats still owed on the output
   replay_pkg::beat_t         stored_q[$];
   replay_pkg::beat_t         expect_q[$];
   replay_pkg::beat_t         head_beat;
   logic                      wr_done_ref;
   replay_pkg::replay_count_t replay_count_ref;
   logic                      random_ready;
   logic [31:0]               ready_bits;
   int                        seed = 41550;
   int                        total_beats = 0;
   int                        cycles = 0;

   replay_top uut (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_beat(input string name, input replay_pkg::beat_t exp,
                             input replay_pkg::beat_t act);
      if (exp !== act)
         stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_reg(input string name, input replay_pkg::reg_data_t exp,
                            input replay_pkg::reg_data_t act);
      if (exp !== act)
         stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act)
         stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic require_fields(input int got, input int want);
      if (got != want)
         stop_on_error("A line in the vector file has missing or malformed fields");
   endtask

   task automatic write_reg(input replay_pkg::reg_addr_t addr,
                            input replay_pkg::reg_data_t data);
      @(posedge clk_i);
      reg_wr_i <= 1'b1;
      reg_addr_i <= addr;
      reg_wdata_i <= data;
      @(posedge clk_i);
      reg_wr_i <= 1'b0;
      if (addr == replay_pkg::REG_REPLAY_COUNT)
         replay_count_ref = data[15:0];
      if (addr == replay_pkg::REG_CTRL) begin
         if (data[replay_pkg::CTRL_SW_RST_BIT])
            stored_q.delete();
         wr_done_ref = data[replay_pkg::CTRL_WR_DONE_BIT];
         // An accepted start owes the stored sequence once per pass
         if (data[replay_pkg::CTRL_START_BIT] && wr_done_ref && stored_q.size() != 0 &&
             replay_count_ref != '0) begin
            repeat (replay_count_ref)
               foreach (stored_q[i])
                  expect_q.push_back(stored_q[i]);
            total_beats += stored_q.size() * int'(replay_count_ref);
         end
      end
   endtask

   task automatic read_reg(input replay_pkg::reg_addr_t addr,
                           output replay_pkg::reg_data_t data);
      @(posedge clk_i);
      reg_rd_i <= 1'b1;
      reg_addr_i <= addr;
      @(posedge clk_i);
      reg_rd_i <= 1'b0;
      // Read data was registered on the previous edge
      @(posedge clk_i);
      data = reg_rdata_o;
   endtask

   task automatic send_beat(input replay_pkg::beat_t beat);
      @(posedge clk_i);
      s_beat_i <= beat;
      s_valid_i <= 1'b1;
      do begin
         @(posedge clk_i);
      end while (!s_ready_o);
      s_valid_i <= 1'b0;
      stored_q.push_back(beat);
   endtask

   // Fields follow the beat index so every stored slot differs
   task automatic send_pattern(input int count, input logic [31:0] base);
      replay_pkg::beat_t beat;
      for (int i = 0; i < count; i++) begin
         beat.tdata = {base, 32'(i)};
         beat.tkeep = 8'(i * 37);
         beat.tuser = base[31:16] ^ 16'(i);
         beat.tlast = ((i % 8) == 7);
         send_beat(beat);
      end
   endtask

   task automatic check_ready(input logic exp);
      repeat (4) begin
         @(posedge clk_i);
         check_flag("s_ready_o", exp, s_ready_o);
      end
   endtask

   task automatic wait_replay_end();
      replay_pkg::reg_data_t status;
      while (expect_q.size() != 0)
         @(posedge clk_i);
      do begin
         read_reg(replay_pkg::REG_STATUS, status);
      end while (status[16]);
      // Every owed beat has left, so the FIFO must be empty
      check_flag("m_valid_o", 1'b0, m_valid_o);
   endtask

   // m_ready_i stays high unless random back-pressure is on
   initial begin
      m_ready_i <= 1'b1;
      forever begin
         @(posedge clk_i);
         ready_bits = $random(seed);
         m_ready_i <= random_ready ? ready_bits[0] : 1'b1;
      end
   end

   // Output checker and run limit
   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (cycles > 40 * total_beats + 2000)
         stop_on_error($sformatf("Timeout after %0d cycles waiting on the DUT", cycles));
      else if (rst_n_i && m_valid_o && m_ready_i) begin
         if (expect_q.size() == 0)
            stop_on_error("Output beat arrived while no replay beat was expected");
         else begin
            head_beat = expect_q.pop_front();
            check_beat("m_beat_o", head_beat, m_beat_o);
         end
      end
   end

   initial begin
      int                    fd;
      int                    code;
      int                    count;
      logic [7:0]            cmd;
      logic [8*128-1:0]      skip_line;
      logic                  flag;
      logic [31:0]           base;
      logic [63:0]           f_data;
      logic [7:0]            f_keep;
      logic [15:0]           f_user;
      replay_pkg::reg_addr_t addr;
      replay_pkg::reg_data_t data;
      replay_pkg::reg_data_t rdata;
      replay_pkg::beat_t     beat;
      rst_n_i <= 1'b0;
      s_beat_i <= '0;
      s_valid_i <= 1'b0;
      reg_wr_i <= 1'b0;
      reg_rd_i <= 1'b0;
      reg_addr_i <= '0;
      reg_wdata_i <= '0;
      wr_done_ref = 1'b0;
      replay_count_ref = '0;
      random_ready = 1'b0;
      repeat (5) @(posedge clk_i);
      rst_n_i <= 1'b1;
      // Out of reset the output is idle and capture is open
      @(posedge clk_i);
      check_flag("m_valid_o", 1'b0, m_valid_o);
      check_flag("s_ready_o", 1'b1, s_ready_o);
      fd = $fopen("tests/replay_vectors.txt", "r");
      if (fd == 0)
         stop_on_error("Could not open tests/replay_vectors.txt");
      while ($fscanf(fd, " %c", cmd) == 1) begin
         case (cmd)
            "#": code = $fgets(skip_line, fd);
            "W": begin
               code = $fscanf(fd, "%h %h", addr, data);
               require_fields(code, 2);
               write_reg(addr, data);
            end
            "R": begin
               code = $fscanf(fd, "%h %h", addr, data);
               require_fields(code, 2);
               read_reg(addr, rdata);
               check_reg("reg_rdata_o", data, rdata);
            end
            "B": begin
               code = $fscanf(fd, "%h %h %h %h", f_data, f_keep, f_user, flag);
               require_fields(code, 4);
               beat.tdata = f_data;
               beat.tkeep = f_keep;
               beat.tuser = f_user;
               beat.tlast = flag;
               send_beat(beat);
            end
            "G": begin
               code = $fscanf(fd, "%h %h", count, base);
               require_fields(code, 2);
               send_pattern(count, base);
            end
            "M": begin
               code = $fscanf(fd, "%h", flag);
               require_fields(code, 1);
               random_ready = flag;
            end
            "F": begin
               code = $fscanf(fd, "%h", flag);
               require_fields(code, 1);
               check_ready(flag);
            end
            "D": wait_replay_end();
            default: stop_on_error($sformatf("Unknown command %c in the vector file", cmd));
         endcase
      end
      $fclose(fd);
      if (expect_q.size() != 0)
         stop_on_error("Vector file ended with replay beats still missing");
      else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

// ==== sources.f ====
src/replay_pkg.sv
src/replay_regs.sv
src/capture_writer.sv
src/beat_store.sv
src/replay_reader.sv
src/beat_fifo.sv
src/replay_top.sv
tests/replay_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module replay_tb \
   -f sources.f -o replay_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/replay_sim > "$LOG" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
   echo "Simulation passed, see $LOG"
   exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// ==== tests/replay_vectors.txt ====
# All values hex. W addr data, R addr expected, B tdata tkeep tuser tlast
# G count base sends generated beats, M 1 random m_ready, F expected s_ready, D waits for the end
# Five beats captured and replayed once
B 0123456789abcdef ff 1234 0
B fedcba9876543210 0f abcd 0
B 00000000deadbeef f0 0001 0
B 5555aaaa5555aaaa 01 8000 0
B 0f1e2d3c4b5a6978 3f ffff 1
R 2 00000005
W 1 00000001
R 1 00000001
W 0 00000004
R 0 00000004
W 0 00000006
D
R 3 00000001
# Three passes back to back
W 1 00000003
W 0 00000006
D
R 3 00000003
# Replay count of zero gives no output
W 1 00000000
R 1 00000000
W 0 00000006
D
R 3 00000003
# Long replay under random back-pressure
W 0 00000001
R 2 00000000
G 18 00c0ffee
R 2 00000018
W 1 00000004
W 0 00000004
M 1
W 0 00000006
D
M 0
R 3 00000004
# Full store, then software reset
W 0 00000001
G 20 0badcafe
F 0
R 2 00000020
W 0 00000005
R 2 00000000
F 0
W 0 00000000
F 1
R 0 00000000
